// ==== hdl/fir_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared constants of the single-multiplier fir filter
// configuration address map and tap count
// sample, stream beat, config write and tap array types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package fir_pkg;

    // filter size and datapath width
    localparam int unsigned NUM_TAPS = 11;
    localparam int unsigned DATA_W = 32;

    // tap index counter, wide enough for NUM_TAPS
    localparam int unsigned TAP_IDX_W = 4;

    // configuration address map
    localparam int unsigned ADDR_W = 12;
    // bit 0 is ap_start
    localparam logic [ADDR_W-1:0] ADDR_CTRL = 12'h000;
    // tap k sits at base + 4*k
    localparam logic [ADDR_W-1:0] ADDR_TAP_BASE = 12'h020;

    // signed sample, coefficient and result word
    typedef logic signed [DATA_W-1:0] sample_t;

    // one stream transfer with its end-of-run flag
    typedef struct packed {
        sample_t data;
        logic    last;
    } stream_beat_t;

    // captured write request from the config channel
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        sample_t           data;
    } cfg_write_t;

    // whole coefficient set, entry k is tap[k]
    typedef sample_t [NUM_TAPS-1:0] tap_array_t;

endpackage

// ==== hdl/fir_cfg_write.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write-only config port of the fir filter
// address decode, tap register file and ap_start bit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fir_cfg_write (
    input  logic                        axis_clk,
    input  logic                        axis_rst_n,
    input  logic                        awvalid,
    input  logic                        wvalid,
    input  logic                        run_done,
    input  logic [fir_pkg::ADDR_W-1:0]  awaddr,
    input  fir_pkg::sample_t            wdata,
    output logic                        awready,
    output logic                        wready,
    output logic                        ap_start,
    output fir_pkg::tap_array_t         taps
);
    import fir_pkg::*;

    // one-cycle handshake pulse, shared by aw and w
    logic                 wr_ack;
    // request captured the cycle before the handshake
    cfg_write_t           req;
    logic [ADDR_W-1:0]    tap_off;
    logic [TAP_IDX_W-1:0] tap_idx;
    logic                 tap_hit;
    logic                 ctrl_hit;

    // both channels seen, pulse ready next cycle
    // no back-to-back pulse, the finishing write blocks a new one
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_ack <= 1'b0;
        end else begin
            wr_ack <= awvalid && wvalid && !wr_ack;
        end
    end

    assign awready = wr_ack;
    assign wready  = wr_ack;

    // master holds address and data until the handshake
    always_ff @(posedge axis_clk) begin
        if (awvalid && wvalid && !wr_ack) begin
            req <= '{addr: awaddr, data: wdata};
        end
    end

    // address decode
    assign tap_off  = req.addr - ADDR_TAP_BASE;
    assign tap_idx  = tap_off[TAP_IDX_W+1:2];
    // word aligned and inside the tap window
    assign tap_hit  = (req.addr >= ADDR_TAP_BASE) && (tap_off[1:0] == 2'b00)
                   && (tap_off[ADDR_W-1:2] < NUM_TAPS);
    assign ctrl_hit = (req.addr == ADDR_CTRL);

    // tap register file
    // frozen while a run is active
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            taps <= '0;
        end else if (wr_ack && tap_hit && !ap_start) begin
            taps[tap_idx] <= req.data;
        end
    end

    // start bit
    // set by software, cleared on the tlast output handshake
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ap_start <= 1'b0;
        end else if (run_done) begin
            ap_start <= 1'b0;
        end else if (wr_ack && ctrl_hit && req.data[0]) begin
            ap_start <= 1'b1;
        end
    end

endmodule

// ==== hdl/fir_stream_in.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// input side of the fir filter
// one-beat holding buffer in front of the mac engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fir_stream_in (
    input  logic                  axis_clk,
    input  logic                  axis_rst_n,
    input  logic                  ss_tvalid,
    input  logic                  ap_start,
    input  logic                  in_take,
    input  fir_pkg::stream_beat_t ss_beat,
    output logic                  ss_tready,
    output logic                  in_valid,
    output fir_pkg::stream_beat_t in_beat
);
    import fir_pkg::*;

    logic         full;
    stream_beat_t beat_q;

    // accept only into an empty buffer and only inside a run
    assign ss_tready = !full && ap_start;

    // occupancy flag
    // fill and take never meet, take needs a full buffer
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            full <= 1'b0;
        end else if (ss_tvalid && ss_tready) begin
            full <= 1'b1;
        end else if (in_take) begin
            full <= 1'b0;
        end
    end

    // held sample and last flag
    always_ff @(posedge axis_clk) begin
        if (ss_tvalid && ss_tready) begin
            beat_q <= ss_beat;
        end
    end

    assign in_valid = full;
    assign in_beat  = beat_q;

endmodule

// ==== hdl/fir_mac_engine.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fir datapath with one multiplier and one adder
// sample history, tap index counter and partial sum
// idle / accumulate / offer FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fir_mac_engine (
    input  logic                  axis_clk,
    input  logic                  axis_rst_n,
    input  logic                  ap_start,
    input  logic                  in_valid,
    input  logic                  out_ready,
    input  fir_pkg::tap_array_t   taps,
    input  fir_pkg::stream_beat_t in_beat,
    output logic                  in_take,
    output logic                  out_valid,
    output fir_pkg::stream_beat_t out_beat
);
    import fir_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCUM,
        ST_OFFER
    } state_t;

    state_t               state;
    state_t               state_nxt;
    logic [TAP_IDX_W-1:0] tap_idx;
    logic                 idx_end;

    // history, entry k holds x[n-k]
    sample_t [NUM_TAPS-1:0] hist;
    sample_t                prod;
    sample_t                psum;
    logic                   last_q;

    // one tap per accumulate cycle
    assign idx_end = (tap_idx == TAP_IDX_W'(NUM_TAPS - 1));

    // handshakes
    assign in_take   = (state == ST_IDLE) && in_valid;
    // offer only into an empty output register
    assign out_valid = (state == ST_OFFER) && out_ready;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (in_take) begin
                    state_nxt = ST_ACCUM;
                end
            end
            ST_ACCUM: begin
                if (idx_end) begin
                    state_nxt = ST_OFFER;
                end
            end
            ST_OFFER: begin
                // result handed over, ready for the next beat
                if (out_valid) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // tap index counter, restarts with every new sample
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            tap_idx <= '0;
        end else if (in_take) begin
            tap_idx <= '0;
        end else if (state == ST_ACCUM) begin
            tap_idx <= idx_end ? '0 : tap_idx + 1'b1;
        end
    end

    // sample history
    // zero outside a run so every run starts from x = 0
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            hist <= '0;
        end else if (!ap_start) begin
            hist <= '0;
        end else if (in_take) begin
            hist <= {hist[NUM_TAPS-2:0], in_beat.data};
        end
    end

    // the single multiplier, wraps at DATA_W
    assign prod = taps[tap_idx] * hist[tap_idx];

    // partial sum and the last flag riding with it
    always_ff @(posedge axis_clk) begin
        if (in_take) begin
            psum   <= '0;
            last_q <= in_beat.last;
        end else if (state == ST_ACCUM) begin
            psum <= psum + prod;
        end
    end

    assign out_beat = '{data: psum, last: last_q};

endmodule

// ==== hdl/fir_stream_out.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// output side of the fir filter
// one-entry result register and end-of-run pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fir_stream_out (
    input  logic                  axis_clk,
    input  logic                  axis_rst_n,
    input  logic                  out_valid,
    input  logic                  sm_tready,
    input  fir_pkg::stream_beat_t out_beat,
    output logic                  out_ready,
    output logic                  sm_tvalid,
    output logic                  run_done,
    output fir_pkg::stream_beat_t sm_beat
);
    import fir_pkg::*;

    logic         full;
    logic         sm_fire;
    stream_beat_t beat_q;

    assign sm_fire   = full && sm_tready;
    // engine may only offer into an empty register
    assign out_ready = !full;

    // occupancy flag
    // fill needs an empty register, so fill and drain never coincide
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            full <= 1'b0;
        end else if (out_valid) begin
            full <= 1'b1;
        end else if (sm_fire) begin
            full <= 1'b0;
        end
    end

    // result held stable under back-pressure
    always_ff @(posedge axis_clk) begin
        if (out_valid) begin
            beat_q <= out_beat;
        end
    end

    assign sm_tvalid = full;
    assign sm_beat   = beat_q;

    // end of run, clears ap_start in the config block
    assign run_done = sm_fire && beat_q.last;

endmodule

// ==== hdl/fir.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fir filter top level
// config write port, input buffer, mac engine, output register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fir (
    input  logic                       axis_clk,
    input  logic                       axis_rst_n,
    // config write channel
    input  logic                       awvalid,
    input  logic                       wvalid,
    input  logic [fir_pkg::ADDR_W-1:0] awaddr,
    input  fir_pkg::sample_t           wdata,
    output logic                       awready,
    output logic                       wready,
    // sample stream in
    input  logic                       ss_tvalid,
    input  logic                       ss_tlast,
    input  fir_pkg::sample_t           ss_tdata,
    output logic                       ss_tready,
    // result stream out
    input  logic                       sm_tready,
    output logic                       sm_tvalid,
    output logic                       sm_tlast,
    output fir_pkg::sample_t           sm_tdata
);
    import fir_pkg::*;

    logic         ap_start;
    logic         run_done;
    tap_array_t   taps;
    stream_beat_t ss_beat;
    stream_beat_t in_beat;
    stream_beat_t out_beat;
    stream_beat_t sm_beat;
    logic         in_valid;
    logic         in_take;
    logic         out_valid;
    logic         out_ready;

    // flat bus pins to and from beats
    assign ss_beat  = '{data: ss_tdata, last: ss_tlast};
    assign sm_tdata = sm_beat.data;
    assign sm_tlast = sm_beat.last;

    fir_cfg_write u_cfg (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .wvalid     (wvalid),
        .run_done   (run_done),
        .awaddr     (awaddr),
        .wdata      (wdata),
        .awready    (awready),
        .wready     (wready),
        .ap_start   (ap_start),
        .taps       (taps)
    );

    fir_stream_in u_in (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .ss_tvalid  (ss_tvalid),
        .ap_start   (ap_start),
        .in_take    (in_take),
        .ss_beat    (ss_beat),
        .ss_tready  (ss_tready),
        .in_valid   (in_valid),
        .in_beat    (in_beat)
    );

    fir_mac_engine u_mac (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .ap_start   (ap_start),
        .in_valid   (in_valid),
        .out_ready  (out_ready),
        .taps       (taps),
        .in_beat    (in_beat),
        .in_take    (in_take),
        .out_valid  (out_valid),
        .out_beat   (out_beat)
    );

    fir_stream_out u_out (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .out_valid  (out_valid),
        .sm_tready  (sm_tready),
        .out_beat   (out_beat),
        .out_ready  (out_ready),
        .sm_tvalid  (sm_tvalid),
        .run_done   (run_done),
        .sm_beat    (sm_beat)
    );

endmodule

// ==== test/fir_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent assertions for the fir filter
// output hold under back-pressure, start gating, write ready pairing
// bind of the checker into every fir instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fir_checker (
    input logic             axis_clk,
    input logic             axis_rst_n,
    input logic             ap_start,
    input logic             ss_tready,
    input logic             awvalid,
    input logic             wvalid,
    input logic             awready,
    input logic             wready,
    input logic             sm_tvalid,
    input logic             sm_tready,
    input logic             sm_tlast,
    input fir_pkg::sample_t sm_tdata
);
    timeunit 1ns;
    timeprecision 1ps;

    // a stalled result keeps valid, data and last
    hold_under_stall: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast)
    ) else $error("sm_tvalid or its payload changed while sm_tready was low");

    // the tlast handshake ends the run and closes the input
    gated_by_start: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && sm_tready && sm_tlast |=> !ap_start && !ss_tready
    ) else $error("ap_start or ss_tready still high after the tlast handshake");

    // aw and w complete together in a one-cycle pulse after both were offered
    ready_pair: assert property (
        @(posedge axis_clk) disable iff (!axis_rst_n)
        awready || wready |-> awready && wready && $past(awvalid && wvalid)
            ##1 !awready && !wready
    ) else $error("awready and wready do not form one paired pulse after valid");

endmodule

bind fir fir_checker u_chk (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .ap_start   (ap_start),
    .ss_tready  (ss_tready),
    .awvalid    (awvalid),
    .wvalid     (wvalid),
    .awready    (awready),
    .wready     (wready),
    .sm_tvalid  (sm_tvalid),
    .sm_tready  (sm_tready),
    .sm_tlast   (sm_tlast),
    .sm_tdata   (sm_tdata)
);

// ==== test/fir_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the fir filter
// clock, reset, stimulus table, reference model and checks
// watchdog against a hung run
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fir_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import fir_pkg::*;

    localparam int          CLK_PERIOD = 8;
    localparam int          RST_CYCLES = 10;
    localparam int          NUM_TESTS  = 5;
    localparam int          MAX_SAMP   = 32;
    localparam int          MARGIN_NS  = 10000;
    localparam logic [31:0] SEED       = 32'hb9c9;

    logic              axis_clk;
    logic              axis_rst_n;
    logic              awvalid;
    logic              wvalid;
    logic [ADDR_W-1:0] awaddr;
    sample_t           wdata;
    logic              awready;
    logic              wready;
    logic              ss_tvalid;
    logic              ss_tlast;
    sample_t           ss_tdata;
    logic              ss_tready;
    logic              sm_tready;
    logic              sm_tvalid;
    logic              sm_tlast;
    sample_t           sm_tdata;

    // stimulus table, one row per test
    string      test_name [NUM_TESTS];
    int         n_samp    [NUM_TESTS];
    // 0 sm_tready always high, 1 random
    int         bp_mode   [NUM_TESTS];
    // rewrite the taps in the middle of the run
    bit         tap_poke  [NUM_TESTS];
    cfg_write_t tap_wr    [NUM_TESTS][NUM_TAPS];
    sample_t    samp      [NUM_TESTS][MAX_SAMP];
    // results of the previous run, for the back-pressure comparison
    sample_t    last_run  [MAX_SAMP];

    int checks;
    int errors;
    bit table_built;

    fir UUT (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .wvalid     (wvalid),
        .awaddr     (awaddr),
        .wdata      (wdata),
        .awready    (awready),
        .wready     (wready),
        .ss_tvalid  (ss_tvalid),
        .ss_tlast   (ss_tlast),
        .ss_tdata   (ss_tdata),
        .ss_tready  (ss_tready),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tlast   (sm_tlast),
        .sm_tdata   (sm_tdata)
    );

    initial begin
        axis_clk = 1'b0;
        forever #(CLK_PERIOD / 2) axis_clk = ~axis_clk;
    end

    task automatic fill_table();
        test_name = '{"impulse", "random", "backpressure", "restart", "tap_write"};
        n_samp    = '{11, 30, 30, 5, 12};
        bp_mode   = '{0, 0, 1, 0, 0};
        tap_poke  = '{0, 0, 0, 0, 1};
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int k = 0; k < NUM_TAPS; k++) begin
                tap_wr[t][k].addr = ADDR_TAP_BASE + ADDR_W'(4 * k);
                tap_wr[t][k].data = (t == 0) ? sample_t'(k + 1) : sample_t'($urandom);
            end
            // impulse: a single 1 then zeros
            for (int i = 0; i < MAX_SAMP; i++) begin
                samp[t][i] = (t == 0) ? sample_t'(i == 0) : sample_t'($urandom);
            end
        end
        // back-pressure repeats the random run
        tap_wr[2] = tap_wr[1];
        samp[2]   = samp[1];
    endtask

    // y[n] = sum tap[k] * x[n-k], zero before the run, wraps at 32 bits
    function automatic sample_t ref_out(input int t, input int n);
        sample_t acc;
        acc = '0;
        for (int k = 0; k < NUM_TAPS; k++) begin
            if (n - k >= 0) begin
                acc = acc + tap_wr[t][k].data * samp[t][n-k];
            end
        end
        return acc;
    endfunction

    task automatic compare(input string name, input sample_t expected, input sample_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    // hold aw and w until the ready pulse, drop them after it
    task automatic cfg_write(input cfg_write_t req);
        @(negedge axis_clk);
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = req.addr;
        wdata   = req.data;
        do begin
            @(negedge axis_clk);
        end while (!awready);
        @(negedge axis_clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    // nothing may move between runs
    task automatic idle_check(input string where);
        repeat (8) begin
            @(negedge axis_clk);
            if (ss_tready) begin
                errors++;
                $display("%s: ss_tready is high without a start write", where);
            end
            if (sm_tvalid) begin
                errors++;
                $display("%s: sm_tvalid is high with no result pending", where);
            end
        end
    endtask

    task automatic drive_samples(input int t);
        int i;
        i = 0;
        while (i < n_samp[t]) begin
            @(negedge axis_clk);
            ss_tvalid = 1'b1;
            ss_tdata  = samp[t][i];
            ss_tlast  = (i == n_samp[t] - 1);
            // ss_tready is registered, so this is what the next edge sees
            if (ss_tready) begin
                i++;
            end
        end
        @(negedge axis_clk);
        ss_tvalid = 1'b0;
        ss_tlast  = 1'b0;
    endtask

    task automatic collect_results(input int t);
        int k;
        k = 0;
        while (k < n_samp[t]) begin
            @(negedge axis_clk);
            sm_tready = (bp_mode[t] != 0) ? 1'($urandom % 2) : 1'b1;
            if (sm_tvalid && sm_tready) begin
                compare($sformatf("%s y[%0d]", test_name[t], k), ref_out(t, k), sm_tdata);
                compare($sformatf("%s tlast[%0d]", test_name[t], k),
                        sample_t'(k == n_samp[t] - 1), sample_t'(sm_tlast));
                if (bp_mode[t] != 0) begin
                    compare($sformatf("%s vs ready run[%0d]", test_name[t], k),
                            last_run[k], sm_tdata);
                end
                last_run[k] = sm_tdata;
                k++;
            end
        end
    endtask

    // inverted taps, must be dropped while ap_start is set
    task automatic poke_taps(input int t);
        cfg_write_t req;
        repeat (20) @(negedge axis_clk);
        for (int k = 0; k < NUM_TAPS; k++) begin
            req      = tap_wr[t][k];
            req.data = ~req.data;
            cfg_write(req);
        end
    endtask

    task automatic run_test(input int t);
        cfg_write_t start_req;
        start_req.addr = ADDR_CTRL;
        start_req.data = sample_t'(1);
        for (int k = 0; k < NUM_TAPS; k++) begin
            cfg_write(tap_wr[t][k]);
        end
        cfg_write(start_req);
        fork
            drive_samples(t);
            collect_results(t);
            if (tap_poke[t]) poke_taps(t);
        join
        idle_check({"after ", test_name[t]});
    endtask

    initial begin
        void'($urandom(SEED));
        axis_rst_n  = 1'b0;
        awvalid     = 1'b0;
        wvalid      = 1'b0;
        awaddr      = '0;
        wdata       = '0;
        ss_tvalid   = 1'b0;
        ss_tlast    = 1'b0;
        ss_tdata    = '0;
        sm_tready   = 1'b1;
        checks      = 0;
        errors      = 0;
        fill_table();
        table_built = 1'b1;
        repeat (RST_CYCLES) @(negedge axis_clk);
        axis_rst_n = 1'b1;
        idle_check("after reset");
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // limit scales with the total sample count
    initial begin
        longint limit_ns;
        wait (table_built);
        limit_ns = MARGIN_NS;
        for (int t = 0; t < NUM_TESTS; t++) begin
            limit_ns += longint'(n_samp[t]) * (NUM_TAPS + 8) * CLK_PERIOD * 4;
        end
        #(limit_ns);
        $display("timeout: the run did not finish within %0d ns", limit_ns);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== fir.f ====
hdl/fir_pkg.sv
hdl/fir_cfg_write.sv
hdl/fir_stream_in.sv
hdl/fir_mac_engine.sv
hdl/fir_stream_out.sv
hdl/fir.sv
test/fir_checker.sv
test/fir_tb.sv

// ==== Bender.yml ====
package:
  name: fir

sources:
  - files:
      - hdl/fir_pkg.sv
      - hdl/fir_cfg_write.sv
      - hdl/fir_stream_in.sv
      - hdl/fir_mac_engine.sv
      - hdl/fir_stream_out.sv
      - hdl/fir.sv
  - target: test
    files:
      - test/fir_checker.sv
      - test/fir_tb.sv
